// File: verilog/lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// first instruction fetched after reset
`define LC3B_RESET_PC 16'h0000

// general purpose registers R0..R7
`define LC3B_NUM_REGS 8

`endif

// File: verilog/lc3b_pkg.sv
package lc3b_pkg;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// LC-3b encodings of the supported subset
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} lc3b_opcode;

typedef struct packed {
	lc3b_opcode opcode;
	logic imm_sel;
	logic reg_write;
	logic cc_write;
	logic mem_read;
	logic mem_write;
} lc3b_control_word;

typedef struct packed {
	lc3b_word npc;
	lc3b_word ir;
} f_de_t;

typedef struct packed {
	lc3b_word npc;
	lc3b_word ir;
	lc3b_control_word cw;
	lc3b_word sr1;
	lc3b_word sr2;
	lc3b_reg dr;
	lc3b_nzp nzp;
} de_ex_t;

typedef struct packed {
	lc3b_control_word cw;
	lc3b_reg dr;
	lc3b_word alu;
	lc3b_word addr;
	lc3b_word sdata;
} ex_mem_t;

endpackage : lc3b_pkg

// File: verilog/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
	parameter type T = logic
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic valid_in,
	input T data_in,
	output logic valid,
	output T data
);

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		valid <= 1'b0;
	else if (load)
		valid <= valid_in;
end

always_ff @(posedge clk) begin
	if (load)
		data <= data_in;
end

endmodule : stage_reg

// File: verilog/fetch.sv
`timescale 1ns/10ps
`include "lc3b_params.svh"

module fetch (
	input logic clk,
	input logic rst_n,
	input logic load_regs,
	input logic load_pc,
	input logic br_taken,
	input lc3b_pkg::lc3b_word br_target,
	input lc3b_pkg::lc3b_word ifetch_rdata,
	output lc3b_pkg::lc3b_word ifetch_addr,
	output logic ifetch_read,
	output lc3b_pkg::lc3b_word npc,
	output lc3b_pkg::lc3b_word ir
);

lc3b_pkg::lc3b_word pc;
lc3b_pkg::lc3b_word pc_plus2;
logic fetch_en;

assign pc_plus2 = pc + 16'd2;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc <= `LC3B_RESET_PC;
		fetch_en <= 1'b0;
	end else begin
		fetch_en <= 1'b1;
		if (load_regs && load_pc)
			pc <= br_taken ? br_target : pc_plus2;
	end
end

assign ifetch_addr = pc;
assign ifetch_read = fetch_en;
// word held by the arbiter until load_regs
assign npc = pc_plus2;
assign ir = ifetch_rdata;

endmodule : fetch

// File: verilog/decode.sv
`timescale 1ns/10ps
`include "lc3b_params.svh"

module decode (
	input logic clk,
	input logic rst_n,
	input logic load_regs,
	input logic valid_in,
	input lc3b_pkg::lc3b_word npc_in,
	input lc3b_pkg::lc3b_word ir_in,
	input logic ex_valid,
	input lc3b_pkg::lc3b_control_word ex_cw,
	input lc3b_pkg::lc3b_reg ex_dr,
	input logic mem_valid,
	input lc3b_pkg::lc3b_control_word mem_cw,
	input lc3b_pkg::lc3b_reg mem_dr,
	input logic wb_en,
	input logic wb_cc_en,
	input lc3b_pkg::lc3b_reg wb_dr,
	input lc3b_pkg::lc3b_word wb_data,
	output lc3b_pkg::de_ex_t de_ex,
	output lc3b_pkg::lc3b_nzp cc,
	output logic valid,
	output logic load_pc
);

lc3b_pkg::lc3b_word regs [`LC3B_NUM_REGS];
lc3b_pkg::lc3b_control_word cw;
lc3b_pkg::lc3b_reg sr1_idx;
lc3b_pkg::lc3b_reg sr2_idx;
lc3b_pkg::lc3b_word sr1_val;
lc3b_pkg::lc3b_word sr2_val;
logic use_sr1;
logic use_sr2;
logic is_br;
logic cc_busy;
logic dep_stall;
logic br_stall;

function automatic logic writes_reg(
	input logic v,
	input lc3b_pkg::lc3b_control_word w,
	input lc3b_pkg::lc3b_reg dr,
	input lc3b_pkg::lc3b_reg idx
);
	return v && w.reg_write && (dr == idx);
endfunction

// unsupported opcodes fall through as no-ops
always_comb begin
	cw = '0;
	cw.opcode = lc3b_pkg::op_add;
	case (ir_in[15:12])
		lc3b_pkg::op_add,
		lc3b_pkg::op_and: begin
			cw.opcode = lc3b_pkg::lc3b_opcode'(ir_in[15:12]);
			cw.imm_sel = ir_in[5];
			cw.reg_write = 1'b1;
			cw.cc_write = 1'b1;
		end
		lc3b_pkg::op_not: begin
			cw.opcode = lc3b_pkg::op_not;
			cw.reg_write = 1'b1;
			cw.cc_write = 1'b1;
		end
		lc3b_pkg::op_ldr: begin
			cw.opcode = lc3b_pkg::op_ldr;
			cw.reg_write = 1'b1;
			cw.cc_write = 1'b1;
			cw.mem_read = 1'b1;
		end
		lc3b_pkg::op_str: begin
			cw.opcode = lc3b_pkg::op_str;
			cw.mem_write = 1'b1;
		end
		lc3b_pkg::op_br: cw.opcode = lc3b_pkg::op_br;
		default: ;
	endcase
end

// STR reads its data register through the second port
assign sr1_idx = ir_in[8:6];
assign sr2_idx = (cw.opcode == lc3b_pkg::op_str) ? ir_in[11:9] : ir_in[2:0];

assign sr1_val = (wb_en && wb_dr == sr1_idx) ? wb_data : regs[sr1_idx];
assign sr2_val = (wb_en && wb_dr == sr2_idx) ? wb_data : regs[sr2_idx];

assign use_sr1 = cw.reg_write || cw.mem_write;
assign use_sr2 = cw.mem_write || (cw.reg_write && !cw.imm_sel &&
	(cw.opcode == lc3b_pkg::op_add || cw.opcode == lc3b_pkg::op_and));
assign is_br = cw.opcode == lc3b_pkg::op_br;
assign cc_busy = (ex_valid && ex_cw.cc_write) || (mem_valid && mem_cw.cc_write);

assign dep_stall = valid_in && (
	(use_sr1 && (writes_reg(ex_valid, ex_cw, ex_dr, sr1_idx) ||
		writes_reg(mem_valid, mem_cw, mem_dr, sr1_idx))) ||
	(use_sr2 && (writes_reg(ex_valid, ex_cw, ex_dr, sr2_idx) ||
		writes_reg(mem_valid, mem_cw, mem_dr, sr2_idx))) ||
	(is_br && cc_busy));
// BR on its way into de_ex, PC holds until execute resolves it
assign br_stall = valid_in && is_br;

assign valid = valid_in && !dep_stall;
assign load_pc = !(dep_stall || br_stall);

always_comb begin
	de_ex.npc = npc_in;
	de_ex.ir = ir_in;
	de_ex.cw = cw;
	de_ex.sr1 = sr1_val;
	de_ex.sr2 = sr2_val;
	de_ex.dr = ir_in[11:9];
	de_ex.nzp = ir_in[11:9];
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			regs[i] <= '0;
	end else if (load_regs && wb_en) begin
		regs[wb_dr] <= wb_data;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		cc <= 3'b010;
	end else if (load_regs && wb_cc_en) begin
		cc[2] <= wb_data[15];
		cc[1] <= wb_data == '0;
		cc[0] <= !wb_data[15] && (|wb_data);
	end
end

endmodule : decode

// File: verilog/execute.sv
`timescale 1ns/10ps

module execute (
	input lc3b_pkg::de_ex_t de_ex,
	input logic valid_in,
	input lc3b_pkg::lc3b_nzp cc,
	output lc3b_pkg::ex_mem_t ex_mem,
	output logic br_taken,
	output lc3b_pkg::lc3b_word br_target
);

lc3b_pkg::lc3b_word imm5;
lc3b_pkg::lc3b_word off6;
lc3b_pkg::lc3b_word off9;
lc3b_pkg::lc3b_word operand_b;
lc3b_pkg::lc3b_word alu;
lc3b_pkg::lc3b_word ea;

// word offsets are shifted left into byte offsets
assign imm5 = {{11{de_ex.ir[4]}}, de_ex.ir[4:0]};
assign off6 = {{9{de_ex.ir[5]}}, de_ex.ir[5:0], 1'b0};
assign off9 = {{6{de_ex.ir[8]}}, de_ex.ir[8:0], 1'b0};

assign operand_b = de_ex.cw.imm_sel ? imm5 : de_ex.sr2;

always_comb begin
	case (de_ex.cw.opcode)
		lc3b_pkg::op_add: alu = de_ex.sr1 + operand_b;
		lc3b_pkg::op_and: alu = de_ex.sr1 & operand_b;
		lc3b_pkg::op_not: alu = ~de_ex.sr1;
		default: alu = '0;
	endcase
end

// base register plus offset for LDR and STR
assign ea = de_ex.sr1 + off6;

assign br_target = de_ex.npc + off9;
assign br_taken = valid_in && (de_ex.cw.opcode == lc3b_pkg::op_br) &&
	(|(de_ex.nzp & cc));

always_comb begin
	ex_mem.cw = de_ex.cw;
	ex_mem.dr = de_ex.dr;
	ex_mem.alu = alu;
	ex_mem.addr = ea;
	ex_mem.sdata = de_ex.sr2;
end

endmodule : execute

// File: verilog/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
	input lc3b_pkg::ex_mem_t ex_mem,
	input logic valid_in,
	input lc3b_pkg::lc3b_word dmem_rdata,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_pkg::lc3b_word dmem_addr,
	output lc3b_pkg::lc3b_word dmem_wdata,
	output logic wb_en,
	output logic wb_cc_en,
	output lc3b_pkg::lc3b_reg wb_dr,
	output lc3b_pkg::lc3b_word wb_data
);

// request stays up for the whole step
assign dmem_read = valid_in && ex_mem.cw.mem_read;
assign dmem_write = valid_in && ex_mem.cw.mem_write;
assign dmem_addr = ex_mem.addr;
assign dmem_wdata = ex_mem.sdata;

// applied by decode on the load_regs edge
assign wb_en = valid_in && ex_mem.cw.reg_write;
assign wb_cc_en = valid_in && ex_mem.cw.cc_write;
assign wb_dr = ex_mem.dr;
assign wb_data = ex_mem.cw.mem_read ? dmem_rdata : ex_mem.alu;

endmodule : mem_stage

// File: verilog/arbiter.sv
`timescale 1ns/10ps

module arbiter (
	input logic clk,
	input logic rst_n,
	input logic ifetch_read,
	input lc3b_pkg::lc3b_word ifetch_addr,
	input logic dmem_read,
	input logic dmem_write,
	input lc3b_pkg::lc3b_word dmem_addr,
	input lc3b_pkg::lc3b_word dmem_wdata,
	output lc3b_pkg::lc3b_word ifetch_rdata,
	output lc3b_pkg::lc3b_word dmem_rdata,
	output logic load_regs,
	output lc3b_pkg::lc3b_word pmem_adr,
	output lc3b_pkg::lc3b_word pmem_dat_w,
	output logic pmem_we,
	output logic [1:0] pmem_sel,
	output logic pmem_cyc,
	output logic pmem_stb,
	input lc3b_pkg::lc3b_word pmem_dat_r,
	input logic pmem_ack
);

typedef enum logic [1:0] {st_idle, st_data, st_fetch, st_done} state_t;

state_t state;
logic data_served;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= st_idle;
		data_served <= 1'b0;
	end else begin
		case (state)
			st_idle: begin
				// data access goes first in each step
				if ((dmem_read || dmem_write) && !data_served)
					state <= st_data;
				else if (ifetch_read)
					state <= st_fetch;
			end
			st_data: begin
				if (pmem_ack) begin
					state <= st_idle;
					data_served <= 1'b1;
				end
			end
			st_fetch: begin
				if (pmem_ack)
					state <= st_done;
			end
			st_done: begin
				state <= st_idle;
				data_served <= 1'b0;
			end
		endcase
	end
end

always_ff @(posedge clk) begin
	if (state == st_data && pmem_ack)
		dmem_rdata <= pmem_dat_r;
	if (state == st_fetch && pmem_ack)
		ifetch_rdata <= pmem_dat_r;
end

assign pmem_cyc = (state == st_data) || (state == st_fetch);
assign pmem_stb = pmem_cyc;
assign pmem_we = (state == st_data) && dmem_write;
assign pmem_adr = (state == st_data) ? dmem_addr : ifetch_addr;
assign pmem_dat_w = dmem_wdata;
assign pmem_sel = 2'b11;
assign load_regs = state == st_done;

endmodule : arbiter

// File: verilog/lc3b_pipe.sv
`timescale 1ns/10ps

module lc3b_pipe (
	input logic clk,
	input logic rst_n,
	output lc3b_pkg::lc3b_word pmem_adr,
	output lc3b_pkg::lc3b_word pmem_dat_w,
	output logic pmem_we,
	output logic [1:0] pmem_sel,
	output logic pmem_cyc,
	output logic pmem_stb,
	input lc3b_pkg::lc3b_word pmem_dat_r,
	input logic pmem_ack
);

logic load_regs;
logic load_pc;
logic load_de;
logic br_taken;
lc3b_pkg::lc3b_word br_target;
lc3b_pkg::lc3b_nzp cc;

logic ifetch_read;
lc3b_pkg::lc3b_word ifetch_addr;
lc3b_pkg::lc3b_word ifetch_rdata;
logic dmem_read;
logic dmem_write;
lc3b_pkg::lc3b_word dmem_addr;
lc3b_pkg::lc3b_word dmem_wdata;
lc3b_pkg::lc3b_word dmem_rdata;

lc3b_pkg::lc3b_word fetch_npc;
lc3b_pkg::lc3b_word fetch_ir;
lc3b_pkg::f_de_t f_de_in;
lc3b_pkg::f_de_t f_de_q;
logic f_de_valid_in;
logic f_de_valid;

lc3b_pkg::de_ex_t de_ex_in;
lc3b_pkg::de_ex_t de_ex_q;
logic de_valid;
logic de_ex_valid;

lc3b_pkg::ex_mem_t ex_mem_in;
lc3b_pkg::ex_mem_t ex_mem_q;
logic ex_mem_valid;

logic wb_en;
logic wb_cc_en;
lc3b_pkg::lc3b_reg wb_dr;
lc3b_pkg::lc3b_word wb_data;

// fetch is a bubble while the PC waits or a taken branch redirects it
assign f_de_valid_in = load_pc && !br_taken;
// a valid instruction dropped by decode means a dependency stall
assign load_de = !f_de_valid || de_valid;
assign f_de_in = '{npc: fetch_npc, ir: fetch_ir};

fetch fetch_i (
	.clk, .rst_n, .load_regs, .load_pc, .br_taken, .br_target,
	.ifetch_rdata, .ifetch_addr, .ifetch_read,
	.npc(fetch_npc), .ir(fetch_ir)
);

stage_reg #(.T(lc3b_pkg::f_de_t)) f_de (
	.clk, .rst_n, .load(load_de && load_regs),
	.valid_in(f_de_valid_in), .data_in(f_de_in),
	.valid(f_de_valid), .data(f_de_q)
);

decode decode_i (
	.clk, .rst_n, .load_regs,
	.valid_in(f_de_valid), .npc_in(f_de_q.npc), .ir_in(f_de_q.ir),
	.ex_valid(de_ex_valid), .ex_cw(de_ex_q.cw), .ex_dr(de_ex_q.dr),
	.mem_valid(ex_mem_valid), .mem_cw(ex_mem_q.cw), .mem_dr(ex_mem_q.dr),
	.wb_en, .wb_cc_en, .wb_dr, .wb_data,
	.de_ex(de_ex_in), .cc, .valid(de_valid), .load_pc
);

// back stages never hold, they advance on every step
stage_reg #(.T(lc3b_pkg::de_ex_t)) de_ex (
	.clk, .rst_n, .load(load_regs),
	.valid_in(de_valid), .data_in(de_ex_in),
	.valid(de_ex_valid), .data(de_ex_q)
);

execute execute_i (
	.de_ex(de_ex_q), .valid_in(de_ex_valid), .cc,
	.ex_mem(ex_mem_in), .br_taken, .br_target
);

stage_reg #(.T(lc3b_pkg::ex_mem_t)) ex_mem (
	.clk, .rst_n, .load(load_regs),
	.valid_in(de_ex_valid), .data_in(ex_mem_in),
	.valid(ex_mem_valid), .data(ex_mem_q)
);

mem_stage mem_stage_i (
	.ex_mem(ex_mem_q), .valid_in(ex_mem_valid), .dmem_rdata,
	.dmem_read, .dmem_write, .dmem_addr, .dmem_wdata,
	.wb_en, .wb_cc_en, .wb_dr, .wb_data
);

arbiter arbiter_i (
	.clk, .rst_n,
	.ifetch_read, .ifetch_addr,
	.dmem_read, .dmem_write, .dmem_addr, .dmem_wdata,
	.ifetch_rdata, .dmem_rdata, .load_regs,
	.pmem_adr, .pmem_dat_w, .pmem_we, .pmem_sel, .pmem_cyc, .pmem_stb,
	.pmem_dat_r, .pmem_ack
);

endmodule : lc3b_pipe

// File: dv/lc3b_assertions.sv
`timescale 1ns/10ps

module lc3b_assertions (
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_word pmem_adr,
	input lc3b_pkg::lc3b_word pmem_dat_w,
	input logic pmem_we,
	input logic pmem_cyc,
	input logic pmem_stb,
	input logic pmem_ack,
	input logic load_regs
);

// set once any rule below has been broken
logic failed = 1'b0;

// master holds the request until the slave acks
property req_held_until_ack;
	@(posedge clk) disable iff (!rst_n)
	(pmem_stb && !pmem_ack) |=>
		($stable(pmem_adr) && $stable(pmem_dat_w) && $stable(pmem_we));
endproperty

property idle_in_reset;
	@(posedge clk) !rst_n |-> (!pmem_cyc && !pmem_stb);
endproperty

// stage latches only move between bus cycles
property no_step_during_cycle;
	@(posedge clk) disable iff (!rst_n) !(load_regs && pmem_cyc);
endproperty

req_stable_a: assert property (req_held_until_ack)
	else begin
		$error("Wishbone address, data or we changed while waiting for ack");
		failed = 1'b1;
	end
reset_idle_a: assert property (idle_in_reset)
	else begin
		$error("Wishbone cyc or stb high during reset");
		failed = 1'b1;
	end
load_regs_a: assert property (no_step_during_cycle)
	else begin
		$error("load_regs high while a Wishbone cycle is open");
		failed = 1'b1;
	end

endmodule : lc3b_assertions

// File: dv/lc3b_tb.sv
`timescale 1ns/10ps
`include "lc3b_params.svh"

module lc3b_tb;

localparam logic [3:0] opc_br = 4'b0000;
localparam logic [3:0] opc_add = 4'b0001;
localparam logic [3:0] opc_and = 4'b0101;
localparam logic [3:0] opc_ldr = 4'b0110;
localparam logic [3:0] opc_str = 4'b0111;
localparam logic [3:0] opc_not = 4'b1001;
// BRnzp with offset -1
localparam logic [15:0] self_loop = 16'h0fff;
localparam int store_timeout = 5000;

logic clk;
logic rst_n;
lc3b_pkg::lc3b_word pmem_adr;
lc3b_pkg::lc3b_word pmem_dat_w;
logic pmem_we;
logic [1:0] pmem_sel;
logic pmem_cyc;
logic pmem_stb;
lc3b_pkg::lc3b_word pmem_dat_r = '0;
logic pmem_ack = 1'b0;

logic [15:0] mem [512];
logic [15:0] iss_mem [512];
logic [2:0] ack_delay [256];
logic [15:0] exp_addr [$];
logic [15:0] exp_data [$];
logic [15:0] exp_a;
logic [15:0] exp_d;
int exp_total;
int stores_seen = 0;
int gen_pc;
logic [7:0] xfer_count = '0;
logic [2:0] ack_wait = '0;
logic xfer_active = 1'b0;

lc3b_pipe dut (
	.clk, .rst_n, .pmem_adr, .pmem_dat_w, .pmem_we, .pmem_sel,
	.pmem_cyc, .pmem_stb, .pmem_dat_r, .pmem_ack
);

bind arbiter lc3b_assertions arbiter_checks (
	.clk, .rst_n, .pmem_adr, .pmem_dat_w, .pmem_we,
	.pmem_cyc, .pmem_stb, .pmem_ack, .load_regs
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

task automatic stop_with_fail();
	$display("=== FAIL ===");
	$fatal(1, "simulation stopped on error");
endtask

task automatic report_problem(string why);
	$display("ERROR at %0t: %s", $time, why);
	stop_with_fail();
endtask

task automatic report_mismatch(string sig, logic [15:0] expected, logic [15:0] actual);
	$display("CHECK FAILED at %0t: %s expected %h got %h", $time, sig, expected, actual);
	stop_with_fail();
endtask

function automatic logic [15:0] enc_reg(logic [3:0] op, logic [2:0] dr,
	logic [2:0] sr1, logic [2:0] sr2);
	return {op, dr, sr1, 3'b000, sr2};
endfunction

// NOT is the immediate form with all ones in the low bits
function automatic logic [15:0] enc_imm(logic [3:0] op, logic [2:0] dr,
	logic [2:0] sr1, logic [4:0] imm);
	return {op, dr, sr1, 1'b1, imm};
endfunction

function automatic logic [15:0] enc_mem(logic [3:0] op, logic [2:0] r,
	logic [2:0] base, logic [5:0] off);
	return {op, r, base, off};
endfunction

function automatic logic [15:0] enc_br(logic [2:0] nzp, logic [8:0] off);
	return {opc_br, nzp, off};
endfunction

function automatic logic [15:0] random_alu(logic [2:0] d);
	logic [2:0] a;
	logic [2:0] b;
	logic [4:0] imm;
	a = 3'($urandom_range(5, 0));
	b = 3'($urandom_range(5, 0));
	imm = 5'($urandom_range(31, 0));
	case ($urandom_range(4, 0))
		0: return enc_reg(opc_add, d, a, b);
		1: return enc_imm(opc_add, d, a, imm);
		2: return enc_reg(opc_and, d, a, b);
		3: return enc_imm(opc_and, d, a, imm);
		default: return enc_imm(opc_not, d, a, 5'b11111);
	endcase
endfunction

task automatic emit(logic [15:0] word);
	mem[gen_pc] = word;
	gen_pc++;
endtask

task automatic gen_program();
	logic [2:0] d;
	logic [2:0] s;
	int off;
	int skip;
	gen_pc = 0;
	// R6 holds the data base 0x0100 and is never overwritten
	emit(enc_imm(opc_and, 3'd6, 3'd6, 5'd0));
	emit(enc_imm(opc_add, 3'd6, 3'd6, 5'd8));
	repeat (5) emit(enc_reg(opc_add, 3'd6, 3'd6, 3'd6));
	for (int i = 0; i < 6; i++) begin
		emit(enc_imm(opc_and, 3'(i), 3'(i), 5'd0));
		emit(enc_imm(opc_add, 3'(i), 3'(i), 5'($urandom_range(31, 0))));
	end
	while (gen_pc < 96) begin
		d = 3'($urandom_range(5, 0));
		s = 3'($urandom_range(5, 0));
		off = $urandom_range(25, 0);
		case ($urandom_range(4, 0))
			0: begin
				emit(random_alu(d));
				emit(enc_mem(opc_str, d, 3'd6, 6'(off)));
			end
			1: begin
				// load then a dependent use
				emit(enc_mem(opc_ldr, d, 3'd6, 6'(off)));
				emit(enc_imm(opc_add, s, d, 5'($urandom_range(31, 0))));
				emit(enc_mem(opc_str, s, 3'd6, 6'($urandom_range(25, 0))));
			end
			2: begin
				emit(enc_mem(opc_str, s, 3'd6, 6'(off)));
				emit(enc_mem(opc_ldr, d, 3'd6, 6'(off)));
				emit(enc_mem(opc_str, d, 3'd6, 6'($urandom_range(25, 0))));
			end
			3: begin
				// the skipped words are stores so a wrong path shows on the bus
				skip = $urandom_range(3, 1);
				emit(random_alu(d));
				emit(enc_br(3'($urandom_range(7, 1)), 9'(skip)));
				repeat (skip) begin
					s = 3'($urandom_range(5, 0));
					emit(enc_mem(opc_str, s, 3'd6, 6'($urandom_range(25, 0))));
				end
			end
			default: emit(random_alu(d));
		endcase
	end
	for (int i = 0; i < 6; i++)
		emit(enc_mem(opc_str, 3'(i), 3'd6, 6'(26 + i)));
	emit(self_loop);
endtask

// instruction set model recording every store in program order
function automatic void run_iss();
	logic [15:0] r [8];
	logic [15:0] pc;
	logic [15:0] ir;
	logic [15:0] b;
	logic [15:0] ea;
	logic [15:0] res;
	logic [2:0] cc;
	int steps;
	for (int i = 0; i < 8; i++)
		r[i] = '0;
	pc = `LC3B_RESET_PC;
	cc = 3'b010;
	res = '0;
	steps = 0;
	ir = iss_mem[pc[9:1]];
	while (ir != self_loop && steps < 4096) begin
		pc = pc + 16'd2;
		b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
		ea = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
		case (ir[15:12])
			opc_add: res = r[ir[8:6]] + b;
			opc_and: res = r[ir[8:6]] & b;
			opc_not: res = ~r[ir[8:6]];
			opc_ldr: res = iss_mem[ea[9:1]];
			opc_str: begin
				exp_addr.push_back(ea);
				exp_data.push_back(r[ir[11:9]]);
				iss_mem[ea[9:1]] = r[ir[11:9]];
			end
			opc_br: begin
				if (|(ir[11:9] & cc))
					pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
			end
			default: ;
		endcase
		if (ir[15:12] inside {opc_add, opc_and, opc_not, opc_ldr}) begin
			r[ir[11:9]] = res;
			cc = {res[15], res == 16'h0000, !res[15] && res != 16'h0000};
		end
		steps++;
		ir = iss_mem[pc[9:1]];
	end
endfunction

// memory slave acking after a table-driven delay of 0 to 5 cycles
always @(negedge clk) begin
	if (pmem_ack) begin
		pmem_ack = 1'b0;
		xfer_active = 1'b0;
	end else if (rst_n && pmem_cyc && pmem_stb) begin
		if (!xfer_active) begin
			xfer_active = 1'b1;
			ack_wait = ack_delay[xfer_count];
			xfer_count = xfer_count + 8'd1;
		end
		if (ack_wait == 3'd0) begin
			if (pmem_we)
				mem[pmem_adr[9:1]] = pmem_dat_w;
			else
				pmem_dat_r = mem[pmem_adr[9:1]];
			pmem_ack = 1'b1;
		end else begin
			ack_wait = ack_wait - 3'd1;
		end
	end
end

always @(negedge clk) begin
	if (dut.arbiter_i.arbiter_checks.failed)
		report_problem("a Wishbone or pipeline-control assertion failed");
end

always @(posedge clk) begin
	if (rst_n && pmem_cyc && pmem_stb && pmem_ack) begin
		assert (pmem_sel == 2'b11)
			else report_mismatch("pmem_sel", 16'h0003, 16'(pmem_sel));
	end
	if (rst_n && pmem_cyc && pmem_stb && pmem_we && pmem_ack) begin
		if (exp_addr.size() == 0) begin
			report_problem("DUT wrote memory after the last expected store");
		end else begin
			exp_a = exp_addr.pop_front();
			exp_d = exp_data.pop_front();
			assert (pmem_adr == exp_a)
				else report_mismatch("pmem_adr", exp_a, pmem_adr);
			assert (pmem_dat_w == exp_d)
				else report_mismatch("pmem_dat_w", exp_d, pmem_dat_w);
			stores_seen++;
		end
	end
end

task automatic wait_first_fetch();
	int cycles;
	cycles = 0;
	while (!pmem_cyc && cycles < 20) begin
		@(negedge clk);
		cycles++;
	end
	if (!pmem_cyc)
		report_problem("no Wishbone cycle started after reset");
	assert (!pmem_we)
		else report_problem("first Wishbone cycle after reset is a write");
	assert (pmem_adr == `LC3B_RESET_PC)
		else report_mismatch("pmem_adr", `LC3B_RESET_PC, pmem_adr);
endtask

task automatic wait_all_stores();
	int last;
	int cycles;
	while (stores_seen < exp_total) begin
		last = stores_seen;
		cycles = 0;
		while (stores_seen == last && cycles < store_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (stores_seen == last)
			report_problem($sformatf("timeout waiting for store %0d of %0d",
				last + 1, exp_total));
	end
endtask

initial begin
	rst_n = 1'b0;
	void'($urandom(32'h445d));
	for (int i = 0; i < 512; i++)
		mem[i] = 16'(i * 40503) ^ 16'h3c5a;
	for (int i = 0; i < 256; i++)
		ack_delay[i] = 3'($urandom_range(5, 0));
	gen_program();
	iss_mem = mem;
	run_iss();
	exp_total = exp_addr.size();
	$display("program of %0d words, %0d stores expected", gen_pc, exp_total);
	repeat (2) @(posedge clk);
	@(negedge clk);
	assert (!pmem_cyc && !pmem_stb && !pmem_we)
		else report_problem("Wishbone cyc, stb or we high during reset");
	rst_n = 1'b1;
	wait_first_fetch();
	wait_all_stores();
	// give a stray store from a wrong path time to show up
	repeat (200) @(negedge clk);
	$display("=== PASS ===");
	$finish;
end

endmodule : lc3b_tb

// File: filelist.f
+incdir+verilog
verilog/lc3b_pkg.sv
verilog/stage_reg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/mem_stage.sv
verilog/arbiter.sv
verilog/lc3b_pipe.sv
dv/lc3b_assertions.sv
dv/lc3b_tb.sv
